// File: bench/exec_unit_properties.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_unit_properties (
  input logic                   clk,
  input logic                   rst,
  input logic                   issue,
  input exec_pkg::exec_op_t     op,
  input logic [`EXEC_XLEN-1:0]  a,
  input logic [`EXEC_XLEN-1:0]  b,
  input logic [`EXEC_REG_W-1:0] rd,
  input logic                   done,
  input logic [`EXEC_XLEN-1:0]  result,
  input logic [`EXEC_REG_W-1:0] done_rd,
  input logic                   busy
);

  localparam int D = `EXEC_DEPTH;

  int error_count = 0;

  // issue history, entry D is the slot retiring this cycle
  logic                   hist_issue [0:D];
  exec_pkg::exec_op_t     hist_op    [0:D];
  logic [`EXEC_XLEN-1:0]  hist_a     [0:D];
  logic [`EXEC_XLEN-1:0]  hist_b     [0:D];
  logic [`EXEC_REG_W-1:0] hist_rd    [0:D];

  logic                  issue_seen;
  int                    busy_left;  // cycles of busy still owed
  logic [`EXEC_XLEN-1:0] exp_result;

  function automatic logic is_mdu(input exec_pkg::exec_op_t o);
    return (o == exec_pkg::OP_MULT) || (o == exec_pkg::OP_DIV);
  endfunction

  // reference results straight from the op definitions
  function automatic logic [`EXEC_XLEN-1:0] expected_result(
    input exec_pkg::exec_op_t    o,
    input logic [`EXEC_XLEN-1:0] x,
    input logic [`EXEC_XLEN-1:0] y
  );
    logic [2*`EXEC_XLEN-1:0] full_product;
    full_product = {{`EXEC_XLEN{1'b0}}, x} * {{`EXEC_XLEN{1'b0}}, y};
    case (o)
      exec_pkg::OP_AND:  return x & y;
      exec_pkg::OP_OR:   return x | y;
      exec_pkg::OP_ADD:  return x + y;
      exec_pkg::OP_SUB:  return x - y;
      exec_pkg::OP_MULT: return full_product[`EXEC_XLEN-1:0];  // low word
      exec_pkg::OP_DIV:  return (y == '0) ? '1 : x / y;
      default:           return 'x;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i <= D; i++) begin
        hist_issue[i] <= 1'b0;
      end
    end else begin
      hist_issue[0] <= issue;
      for (int i = 1; i <= D; i++) begin
        hist_issue[i] <= hist_issue[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    hist_op[0] <= op;
    hist_a[0]  <= a;
    hist_b[0]  <= b;
    hist_rd[0] <= rd;
    for (int i = 1; i <= D; i++) begin
      hist_op[i] <= hist_op[i-1];
      hist_a[i]  <= hist_a[i-1];
      hist_b[i]  <= hist_b[i-1];
      hist_rd[i] <= hist_rd[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      issue_seen <= 1'b0;
      busy_left  <= 0;
    end else begin
      if (issue) begin
        issue_seen <= 1'b1;
      end
      if (issue && (busy_left == 0) && is_mdu(op)) begin
        busy_left <= (op == exec_pkg::OP_DIV) ? `EXEC_DIV_CYCLES : `EXEC_MULT_CYCLES;
      end else if (busy_left != 0) begin
        busy_left <= busy_left - 1;
      end
    end
  end

  assign exp_result = expected_result(hist_op[D], hist_a[D], hist_b[D]);

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst)
    !issue_seen |-> (!done && !busy))
  else begin
    error_count = error_count + 1;
    $error("done or busy went high before anything was issued");
  end

  a_done_timing: assert property (@(posedge clk) disable iff (!rst)
    done == hist_issue[D])
  else begin
    error_count = error_count + 1;
    $error("ERR t=%0t done expected %b got %b", $time, $sampled(hist_issue[D]),
           $sampled(done));
  end

  a_done_rd: assert property (@(posedge clk) disable iff (!rst)
    done |-> (done_rd == hist_rd[D]))
  else begin
    error_count = error_count + 1;
    $error("ERR t=%0t done_rd expected %0d got %0d", $time, $sampled(hist_rd[D]),
           $sampled(done_rd));
  end

  a_result: assert property (@(posedge clk) disable iff (!rst)
    done |-> (result == exp_result))
  else begin
    error_count = error_count + 1;
    $error("ERR t=%0t result expected %h got %h", $time, $sampled(exp_result),
           $sampled(result));
  end

  a_busy_length: assert property (@(posedge clk) disable iff (!rst)
    busy == (busy_left != 0))
  else begin
    error_count = error_count + 1;
    $error("ERR t=%0t busy expected %b got %b", $time, $sampled(busy_left != 0),
           $sampled(busy));
  end

  a_no_mdu_while_busy: assert property (@(posedge clk) disable iff (!rst)
    (issue && busy) |-> !is_mdu(op))
  else begin
    error_count = error_count + 1;
    $error("a multiply or divide was issued while the unit was still busy");
  end

endmodule

// File: bench/exec_unit_tb.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_unit_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int NUM_DIRECTED   = 18;
  localparam int NUM_RANDOM     = 200;
  localparam int NUM_OPS        = NUM_DIRECTED + NUM_RANDOM;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (`EXEC_DIV_CYCLES + `EXEC_DEPTH) + 50;

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   issue;
  exec_pkg::exec_op_t     op;
  logic [`EXEC_XLEN-1:0]  a;
  logic [`EXEC_XLEN-1:0]  b;
  logic [`EXEC_REG_W-1:0] rd;
  logic                   done;
  logic [`EXEC_XLEN-1:0]  result;
  logic [`EXEC_REG_W-1:0] done_rd;
  logic                   busy;

  logic [31:0] seed = 32'hf2f4_4c9a;
  int issued    = 0;
  int retired   = 0;
  int div_count = 0;
  int tb_errors = 0;
  int assert_errors;

  exec_unit exec_unit_inst (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .op      (op),
    .a       (a),
    .b       (b),
    .rd      (rd),
    .done    (done),
    .result  (result),
    .done_rd (done_rd),
    .busy    (busy)
  );

  bind exec_unit exec_unit_properties properties_inst (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .op      (op),
    .a       (a),
    .b       (b),
    .rd      (rd),
    .done    (done),
    .result  (result),
    .done_rd (done_rd),
    .busy    (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // outputs are steady mid-cycle
  always @(negedge clk) begin
    if (rst && done) begin
      retired++;
    end
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // called just after a falling edge, returns one falling edge later
  task automatic issue_op(input exec_pkg::exec_op_t o, input logic [31:0] x,
                          input logic [31:0] y, input logic [4:0] r);
    issue = 1'b1;
    op    = o;
    a     = x;
    b     = y;
    rd    = r;
    issued++;
    @(negedge clk);
    issue = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    issue = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_unit_free();
    while (busy) @(negedge clk);
  endtask

  task automatic random_op(input int index);
    logic [31:0]        r;
    exec_pkg::exec_op_t o;
    logic [31:0]        x;
    logic [31:0]        y;
    r = next_random();
    o = exec_pkg::exec_op_t'(3'(r[31:16] % 6));  // upper bits, low ones cycle short
    x = next_random();
    y = next_random();
    if (o == exec_pkg::OP_MULT || o == exec_pkg::OP_DIV) begin
      wait_unit_free();
    end
    if (o == exec_pkg::OP_DIV) begin
      div_count++;
      if (div_count % 5 == 0) begin
        y = '0;
      end else begin
        y = y >> (r[27:23] % 28);  // smaller divisors, larger quotients
      end
    end
    issue_op(o, x, y, 5'(index));
    if (r[30:29] == 2'b00) begin
      idle_cycles(1 + r[21:20]);
    end
  endtask

  initial begin
    rst   = 1'b0;
    issue = 1'b0;
    op    = exec_pkg::OP_AND;
    a     = '0;
    b     = '0;
    rd    = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    idle_cycles(5);  // nothing may retire yet

    // back-to-back single-cycle ops
    for (int i = 0; i < 8; i++) begin
      issue_op(exec_pkg::exec_op_t'(3'(i % 4)), next_random(), next_random(), 5'(i));
    end

    // multiply with single-cycle ops behind it
    issue_op(exec_pkg::OP_MULT, next_random(), next_random(), 5'd10);
    for (int i = 0; i < 4; i++) begin
      issue_op(exec_pkg::exec_op_t'(3'(i)), next_random(), next_random(), 5'(11 + i));
    end

    wait_unit_free();
    issue_op(exec_pkg::OP_DIV, next_random(), '0, 5'd16);  // zero divisor
    issue_op(exec_pkg::OP_ADD, next_random(), next_random(), 5'd17);
    issue_op(exec_pkg::OP_SUB, next_random(), next_random(), 5'd18);

    // divide, then multiply in the first free cycle
    wait_unit_free();
    issue_op(exec_pkg::OP_DIV, 32'd100, 32'd7, 5'd19);
    wait_unit_free();
    issue_op(exec_pkg::OP_MULT, 32'hffff_ffff, 32'h0000_0003, 5'd20);
    idle_cycles(`EXEC_DEPTH + 2);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      random_op(i);
    end

    idle_cycles(1);
    while (retired < issued) @(negedge clk);
    idle_cycles(`EXEC_DEPTH + 2);  // catch any stray retirement

    if (issued != retired) begin
      tb_errors++;
      $display("retirement count does not match issue count: %0d issued, %0d retired",
               issued, retired);
    end

    assert_errors = exec_unit_inst.properties_inst.error_count;
    $display("errors: assertions %0d, testbench %0d", assert_errors, tb_errors);
    if (assert_errors == 0 && tb_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // worst case per op is a full divide wait plus the retirement depth
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: exec_unit.f
+incdir+include
hdl/exec_pkg.sv
hdl/align_pipe.sv
hdl/cycle_timer.sv
hdl/mdu_control.sv
hdl/alu_datapath.sv
hdl/exec_unit.sv
bench/exec_unit_properties.sv
bench/exec_unit_tb.sv

// File: hdl/align_pipe.sv
`timescale 1ns/1ps

// delay line of DEPTH register stages
// value sampled at edge t leaves the last stage after edge t+DEPTH-1
module align_pipe #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in,
  output payload_t out
);

  payload_t stage [DEPTH];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= in;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];  // shift every cycle, no stall
      end
    end
  end

  assign out = stage[DEPTH-1];

endmodule

// File: hdl/alu_datapath.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module alu_datapath (
  input  logic                  clk,
  input  logic                  rst,
  input  exec_pkg::exec_op_t    op,
  input  logic [`EXEC_XLEN-1:0] a,
  input  logic [`EXEC_XLEN-1:0] b,
  input  logic                  mdu_start,
  input  logic                  mdu_finish,
  input  exec_pkg::exec_op_t    tail_op,   // op of the retiring slot
  output logic [`EXEC_XLEN-1:0] result
);

  logic [`EXEC_XLEN-1:0] alu_value;
  logic [`EXEC_XLEN-1:0] alu_tail;

  exec_pkg::exec_op_t    mdu_op;
  logic [`EXEC_XLEN-1:0] mdu_a;
  logic [`EXEC_XLEN-1:0] mdu_b;
  logic [`EXEC_XLEN-1:0] product;
  logic [`EXEC_XLEN-1:0] quotient;
  logic [`EXEC_XLEN-1:0] mdu_result;
  logic                  tail_is_mdu;

  // single-cycle ops
  always_comb begin
    case (op)
      exec_pkg::OP_AND: alu_value = a & b;
      exec_pkg::OP_OR:  alu_value = a | b;
      exec_pkg::OP_ADD: alu_value = a + b;
      exec_pkg::OP_SUB: alu_value = a - b;
      default:          alu_value = '0;  // mult/div slot, value unused
    endcase
  end

  // same depth as the tag line so both tails line up
  align_pipe #(
    .payload_t (logic [`EXEC_XLEN-1:0]),
    .DEPTH     (`EXEC_DEPTH + 1)
  ) result_pipe (
    .clk (clk),
    .rst (rst),
    .in  (alu_value),
    .out (alu_tail)
  );

  // operands held steady while the unit runs
  always_ff @(posedge clk) begin
    if (mdu_start) begin
      mdu_op <= op;
      mdu_a  <= a;
      mdu_b  <= b;
    end
  end

  assign product = mdu_a * mdu_b;  // low half only

  // zero divisor gives all ones
  assign quotient = (mdu_b == '0) ? '1 : (mdu_a / mdu_b);

  // lands at edge t+N, stays until the next finish
  always_ff @(posedge clk) begin
    if (mdu_finish) begin
      if (mdu_op == exec_pkg::OP_DIV) begin
        mdu_result <= quotient;
      end else begin
        mdu_result <= product;
      end
    end
  end

  // only one mult/div result is live at a time
  // so the tail can just pick the stored one
  assign tail_is_mdu = (tail_op == exec_pkg::OP_MULT) || (tail_op == exec_pkg::OP_DIV);

  assign result = tail_is_mdu ? mdu_result : alu_tail;

endmodule

// File: hdl/cycle_timer.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module cycle_timer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     timer_load,
  input  logic [`EXEC_TIMER_W-1:0] timer_value,
  output logic                     expired
);

  localparam logic [`EXEC_TIMER_W-1:0] LAST = 1;

  logic [`EXEC_TIMER_W-1:0] count;

  always_ff @(posedge clk) begin
    if (!rst) begin
      count <= '0;
    end else if (timer_load) begin
      count <= timer_value;
    end else if (count != '0) begin
      count <= count - 1'b1;  // sits at zero once drained
    end
  end

  // high in the final counting cycle
  assign expired = (count == LAST);

endmodule

// File: hdl/exec_pkg.sv
`include "exec_defines.svh"

package exec_pkg;

  // operation select at issue
  typedef enum logic [2:0] {
    OP_AND  = 3'd0,
    OP_OR   = 3'd1,
    OP_ADD  = 3'd2,
    OP_SUB  = 3'd3,
    OP_MULT = 3'd4,  // low half of product
    OP_DIV  = 3'd5   // unsigned quotient
  } exec_op_t;

  // travels with each issue slot down to retirement
  typedef struct packed {
    logic                   valid;  // slot holds a real op
    exec_op_t               op;
    logic [`EXEC_REG_W-1:0] rd;
  } exec_tag_t;

  // 1 + 3 + 5 bits

endpackage

// File: hdl/exec_unit.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

// in-order execution unit
// op issued at edge t retires in the cycle after edge t+EXEC_DEPTH
module exec_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue,    // one-cycle strobe
  input  exec_pkg::exec_op_t     op,
  input  logic [`EXEC_XLEN-1:0]  a,
  input  logic [`EXEC_XLEN-1:0]  b,
  input  logic [`EXEC_REG_W-1:0] rd,
  output logic                   done,     // retirement strobe
  output logic [`EXEC_XLEN-1:0]  result,
  output logic [`EXEC_REG_W-1:0] done_rd,
  output logic                   busy      // mult/div unit occupied
);

  logic                     mdu_start;
  logic                     mdu_finish;
  logic                     timer_load;
  logic [`EXEC_TIMER_W-1:0] timer_value;
  logic                     expired;

  exec_pkg::exec_tag_t tag_in;
  exec_pkg::exec_tag_t tag_out;

  assign tag_in = '{valid: issue, op: op, rd: rd};

  mdu_control mdu_control_inst (
    .clk         (clk),
    .rst         (rst),
    .issue       (issue),
    .op          (op),
    .expired     (expired),
    .busy        (busy),
    .mdu_start   (mdu_start),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .mdu_finish  (mdu_finish)
  );

  cycle_timer cycle_timer_inst (
    .clk         (clk),
    .rst         (rst),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .expired     (expired)
  );

  align_pipe #(
    .payload_t (exec_pkg::exec_tag_t),
    .DEPTH     (`EXEC_DEPTH + 1)
  ) tag_pipe (
    .clk (clk),
    .rst (rst),
    .in  (tag_in),
    .out (tag_out)
  );

  alu_datapath alu_datapath_inst (
    .clk        (clk),
    .rst        (rst),
    .op         (op),
    .a          (a),
    .b          (b),
    .mdu_start  (mdu_start),
    .mdu_finish (mdu_finish),
    .tail_op    (tag_out.op),
    .result     (result)
  );

  assign done    = tag_out.valid;
  assign done_rd = tag_out.rd;

endmodule

// File: hdl/mdu_control.sv
`timescale 1ns/1ps
`include "exec_defines.svh"

module mdu_control (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue,
  input  exec_pkg::exec_op_t       op,
  input  logic                     expired,
  output logic                     busy,
  output logic                     mdu_start,
  output logic                     timer_load,
  output logic [`EXEC_TIMER_W-1:0] timer_value,
  output logic                     mdu_finish
);

  // timer reaches its last count N-1 cycles after the load
  // so the finish strobe is sampled N edges after the issue
  localparam logic [`EXEC_TIMER_W-1:0] MULT_LOAD = `EXEC_MULT_CYCLES;
  localparam logic [`EXEC_TIMER_W-1:0] DIV_LOAD  = `EXEC_DIV_CYCLES;

  typedef enum logic [1:0] {
    IDLE,
    MULT_RUN,
    DIV_RUN
  } state_t;

  state_t state;
  state_t state_next;
  logic   is_mult;
  logic   is_div;

  assign is_mult = issue && (op == exec_pkg::OP_MULT);
  assign is_div  = issue && (op == exec_pkg::OP_DIV);

  // a mult/div issued while running is dropped
  assign mdu_start   = (state == IDLE) && (is_mult || is_div);
  assign timer_load  = mdu_start;
  assign timer_value = is_div ? DIV_LOAD : MULT_LOAD;

  assign busy       = (state != IDLE);
  assign mdu_finish = busy && expired;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (is_mult) begin
          state_next = MULT_RUN;
        end else if (is_div) begin
          state_next = DIV_RUN;
        end
      end
      MULT_RUN, DIV_RUN: begin
        if (expired) begin
          state_next = IDLE;  // unit free next cycle
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

// File: include/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// operand and result width
`define EXEC_XLEN 32

// destination register address
`define EXEC_REG_W 5

// cycles from issue to retirement
`define EXEC_DEPTH 6

// multiply and divide latency
// each must stay within 2 and EXEC_DEPTH
`define EXEC_MULT_CYCLES 4
`define EXEC_DIV_CYCLES 6

// holds the largest cycle count
`define EXEC_TIMER_W 4

`endif
